// ==== logic/la_id_pkg.sv ====
package la_id_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int ALU_OP_W = 12;

    // one-hot alu operation bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [1:0] MEM_B = 2'd0;
    localparam logic [1:0] MEM_H = 2'd1;
    localparam logic [1:0] MEM_W = 2'd2;

    // 3r and shift-immediate forms, bits 31:15
    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_SLT    = 17'h00024;
    localparam logic [16:0] OP17_SLTU   = 17'h00025;
    localparam logic [16:0] OP17_NOR    = 17'h00028;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002a;
    localparam logic [16:0] OP17_XOR    = 17'h0002b;
    localparam logic [16:0] OP17_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP17_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP17_SRA_W  = 17'h00030;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W = 17'h00089;
    localparam logic [16:0] OP17_SRAI_W = 17'h00091;

    // 2ri12 forms, bits 31:22
    localparam logic [9:0] OP10_SLTI   = 10'h008;
    localparam logic [9:0] OP10_SLTUI  = 10'h009;
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_XORI   = 10'h00f;
    localparam logic [9:0] OP10_LD_B   = 10'h0a0;
    localparam logic [9:0] OP10_LD_H   = 10'h0a1;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_B   = 10'h0a4;
    localparam logic [9:0] OP10_ST_H   = 10'h0a5;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;
    localparam logic [9:0] OP10_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP10_LD_HU  = 10'h0a9;

    localparam logic [6:0] OP7_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP7_PCADDU12I = 7'h0e;

    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;
    localparam logic [5:0] OP6_BLT  = 6'h18;
    localparam logic [5:0] OP6_BGE  = 6'h19;
    localparam logic [5:0] OP6_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BGEU = 6'h1b;

    localparam logic [3:0] BR_NONE   = 4'd0;
    localparam logic [3:0] BR_EQ     = 4'd1;
    localparam logic [3:0] BR_NE     = 4'd2;
    localparam logic [3:0] BR_LT     = 4'd3;
    localparam logic [3:0] BR_GE     = 4'd4;
    localparam logic [3:0] BR_LTU    = 4'd5;
    localparam logic [3:0] BR_GEU    = 4'd6;
    localparam logic [3:0] BR_JIRL   = 4'd7;
    localparam logic [3:0] BR_ALWAYS = 4'd8;

    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri16;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm20;
            logic [4:0]  rd;
        } ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi; // upper ten bits of the 26-bit offset
        } i26;
    } inst_word_u;

endpackage

// ==== logic/id_dec_if.sv ====
`timescale 1ns/10ps

interface id_dec_if import la_id_pkg::*; ();
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     imm;
    logic                src1_is_pc;
    logic                src2_is_imm;
    logic [REG_AW-1:0]   raddr1;
    logic [REG_AW-1:0]   raddr2;
    logic                need_r1;
    logic                need_r2;
    logic [REG_AW-1:0]   dest;
    logic                gr_we;
    logic                mem_load;
    logic                mem_store;
    logic [1:0]          mem_size;
    logic                mem_unsigned;
    logic [3:0]          br_kind;
    logic [XLEN-1:0]     br_offs;
    logic                ine;

    modport dec (
        output alu_op, imm, src1_is_pc, src2_is_imm, raddr1, raddr2, need_r1, need_r2,
               dest, gr_we, mem_load, mem_store, mem_size, mem_unsigned, br_kind,
               br_offs, ine
    );

    // operand fetch and branch resolution side
    modport user (
        input imm, src1_is_pc, src2_is_imm, raddr1, raddr2, need_r1, need_r2, br_kind,
              br_offs
    );
endinterface

// ==== logic/id_latch.sv ====
`timescale 1ns/10ps

module id_latch import la_id_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_valid,
    input  logic [XLEN-1:0] in_pc,
    input  logic [XLEN-1:0] in_inst,
    input  logic            ready_go,
    input  logic            br_hit,
    input  logic            ex_allowin,
    output logic            allowin,
    output logic            out_valid,
    output logic            br_taken,
    output logic            slot_valid,
    output logic [XLEN-1:0] slot_pc,
    output logic [XLEN-1:0] slot_inst
);
    assign out_valid = slot_valid & ready_go;
    assign allowin   = ~slot_valid | (out_valid & ex_allowin);
    assign br_taken  = out_valid & ex_allowin & br_hit; // pulses in the issue cycle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot_valid <= 1'b0;
        end else if (br_taken) begin
            slot_valid <= 1'b0; // offered word is wrong path
        end else if (allowin) begin
            slot_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            slot_pc   <= in_pc;
            slot_inst <= in_inst;
        end
    end

    a_valid_needs_slot: assert property (@(posedge clk) disable iff (!resetn)
        out_valid |-> slot_valid);
endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder import la_id_pkg::*; (
    input  inst_word_u  slot_inst,
    id_dec_if.dec       d
);
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic        is_3r, is_shi, is_si12, is_ui12, is_load, is_store;
    logic        is_lu12i, is_pcadd, is_jirl, is_b, is_bl, is_cmpbr;
    logic [ALU_OP_W-1:0] alu;

    assign op17 = slot_inst.r3.opcode;
    assign op10 = slot_inst.ri12.opcode;
    assign op7  = slot_inst.ri20.opcode;
    assign op6  = slot_inst.ri16.opcode;

    assign is_3r    = op17 inside {OP17_ADD_W, OP17_SUB_W, OP17_SLT, OP17_SLTU, OP17_NOR,
                                   OP17_AND, OP17_OR, OP17_XOR, OP17_SLL_W, OP17_SRL_W,
                                   OP17_SRA_W};
    assign is_shi   = op17 inside {OP17_SLLI_W, OP17_SRLI_W, OP17_SRAI_W};
    assign is_si12  = op10 inside {OP10_ADDI_W, OP10_SLTI, OP10_SLTUI};
    assign is_ui12  = op10 inside {OP10_ANDI, OP10_ORI, OP10_XORI};
    assign is_load  = op10 inside {OP10_LD_B, OP10_LD_H, OP10_LD_W, OP10_LD_BU, OP10_LD_HU};
    assign is_store = op10 inside {OP10_ST_B, OP10_ST_H, OP10_ST_W};
    assign is_lu12i = op7 == OP7_LU12I_W;
    assign is_pcadd = op7 == OP7_PCADDU12I;
    assign is_jirl  = op6 == OP6_JIRL;
    assign is_b     = op6 == OP6_B;
    assign is_bl    = op6 == OP6_BL;
    assign is_cmpbr = op6 inside {OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU};

    always_comb begin
        alu = '0;
        alu[ALU_ADD]  = op17 == OP17_ADD_W || op10 == OP10_ADDI_W || is_load || is_store
                        || is_jirl || is_bl || is_pcadd; // link and address adds
        alu[ALU_SUB]  = op17 == OP17_SUB_W;
        alu[ALU_SLT]  = op17 == OP17_SLT || op10 == OP10_SLTI;
        alu[ALU_SLTU] = op17 == OP17_SLTU || op10 == OP10_SLTUI;
        alu[ALU_AND]  = op17 == OP17_AND || op10 == OP10_ANDI;
        alu[ALU_NOR]  = op17 == OP17_NOR;
        alu[ALU_OR]   = op17 == OP17_OR || op10 == OP10_ORI;
        alu[ALU_XOR]  = op17 == OP17_XOR || op10 == OP10_XORI;
        alu[ALU_SLL]  = op17 == OP17_SLL_W || op17 == OP17_SLLI_W;
        alu[ALU_SRL]  = op17 == OP17_SRL_W || op17 == OP17_SRLI_W;
        alu[ALU_SRA]  = op17 == OP17_SRA_W || op17 == OP17_SRAI_W;
        alu[ALU_LUI]  = is_lu12i;
    end
    assign d.alu_op = alu;

    assign d.imm = (is_jirl || is_bl)          ? 32'd4 :
                   (is_lu12i || is_pcadd)      ? {slot_inst.ri20.imm20, 12'b0} :
                   is_shi                      ? {27'b0, slot_inst.r3.rk} :
                   (is_si12 || is_load || is_store)
                        ? {{20{slot_inst.ri12.imm12[11]}}, slot_inst.ri12.imm12} :
                   is_ui12                     ? {20'b0, slot_inst.ri12.imm12} :
                   '0;

    assign d.br_offs = (is_b || is_bl)
        ? {{4{slot_inst.i26.offs_hi[9]}}, slot_inst.i26.offs_hi, slot_inst.i26.offs_lo, 2'b0}
        : {{14{slot_inst.ri16.offs16[15]}}, slot_inst.ri16.offs16, 2'b0};

    assign d.src1_is_pc  = is_jirl | is_bl | is_pcadd;
    assign d.src2_is_imm = is_shi | is_si12 | is_ui12 | is_load | is_store | is_lu12i
                         | is_pcadd | is_jirl | is_bl;

    assign d.raddr1  = slot_inst.r3.rj;
    assign d.raddr2  = (is_store || is_cmpbr) ? slot_inst.r3.rd : slot_inst.r3.rk;
    assign d.need_r1 = is_3r | is_shi | is_si12 | is_ui12 | is_load | is_store
                     | is_jirl | is_cmpbr;
    assign d.need_r2 = is_3r | is_store | is_cmpbr;

    assign d.ine   = ~(is_3r | is_shi | is_si12 | is_ui12 | is_load | is_store | is_lu12i
                     | is_pcadd | is_jirl | is_b | is_bl | is_cmpbr);
    assign d.dest  = is_bl ? 5'd1 : slot_inst.r3.rd;
    assign d.gr_we = ~(d.ine | is_store | is_b | is_cmpbr);

    // low opcode bits give size, bit 3 the unsigned loads
    assign d.mem_load     = is_load;
    assign d.mem_store    = is_store;
    assign d.mem_size     = (!(is_load || is_store) || op10[1:0] == 2'd2) ? MEM_W :
                            (op10[1:0] == 2'd1) ? MEM_H : MEM_B;
    assign d.mem_unsigned = is_load & op10[3];

    always_comb begin
        unique case (1'b1)
            is_b, is_bl:          d.br_kind = BR_ALWAYS;
            is_jirl:              d.br_kind = BR_JIRL;
            op6 == OP6_BEQ:       d.br_kind = BR_EQ;
            op6 == OP6_BNE:       d.br_kind = BR_NE;
            op6 == OP6_BLT:       d.br_kind = BR_LT;
            op6 == OP6_BGE:       d.br_kind = BR_GE;
            op6 == OP6_BLTU:      d.br_kind = BR_LTU;
            op6 == OP6_BGEU:      d.br_kind = BR_GEU;
            default:              d.br_kind = BR_NONE;
        endcase
    end
endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/10ps

module regfile import la_id_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2
);
    logic [XLEN-1:0] rf [2**REG_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero on read
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));
endmodule

// ==== logic/operand_fetch.sv ====
`timescale 1ns/10ps

module operand_fetch import la_id_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    id_dec_if.user            d,
    input  logic              slot_valid,
    input  logic [XLEN-1:0]   slot_pc,
    input  logic              ex_bypass,
    input  logic              ex_is_load,
    input  logic [REG_AW-1:0] ex_dest,
    input  logic [XLEN-1:0]   ex_wdata,
    input  logic              mem_bypass,
    input  logic [REG_AW-1:0] mem_dest,
    input  logic [XLEN-1:0]   mem_wdata,
    input  logic              wb_we,
    input  logic [REG_AW-1:0] wb_dest,
    input  logic [XLEN-1:0]   wb_wdata,
    output logic [XLEN-1:0]   rj_value,
    output logic [XLEN-1:0]   rkd_value,
    output logic [XLEN-1:0]   alu_src1,
    output logic [XLEN-1:0]   alu_src2,
    output logic [XLEN-1:0]   store_data,
    output logic              ready_go,
    output logic              br_stall
);
    logic [XLEN-1:0] rf_rdata1, rf_rdata2;
    logic            ld_hit;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (d.raddr1),
        .raddr2 (d.raddr2),
        .we     (wb_we),
        .waddr  (wb_dest),
        .wdata  (wb_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // youngest producer wins
    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] ra, input logic need,
                                            input logic [XLEN-1:0] rf_val);
        logic live;
        live = need && (ra != '0);
        if (live && ex_bypass && ex_dest == ra) return ex_wdata;
        if (live && mem_bypass && mem_dest == ra) return mem_wdata;
        if (live && wb_we && wb_dest == ra) return wb_wdata;
        return rf_val;
    endfunction

    always_comb begin
        rj_value  = fwd(d.raddr1, d.need_r1, rf_rdata1);
        rkd_value = fwd(d.raddr2, d.need_r2, rf_rdata2);
    end

    assign ld_hit = ex_is_load
                  & ((d.need_r1 & (d.raddr1 != '0) & (ex_dest == d.raddr1))
                   | (d.need_r2 & (d.raddr2 != '0) & (ex_dest == d.raddr2)));

    assign ready_go   = ~ld_hit; // load data not yet back
    assign br_stall   = slot_valid & (d.br_kind != BR_NONE) & ld_hit;
    assign alu_src1   = d.src1_is_pc ? slot_pc : rj_value;
    assign alu_src2   = d.src2_is_imm ? d.imm : rkd_value;
    assign store_data = rkd_value;

    a_no_issue_on_load_use: assert property (@(posedge clk) disable iff (!resetn)
        ld_hit |-> !ready_go);
    // a stalled slot must be held by the latch until released
    a_stall_holds_slot: assert property (@(posedge clk) disable iff (!resetn)
        slot_valid && !ready_go |=> slot_valid && $stable(slot_pc));
endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit import la_id_pkg::*; (
    id_dec_if.user          d,
    input  logic [XLEN-1:0] slot_pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    output logic            br_hit,
    output logic [XLEN-1:0] br_target
);
    logic eq, lt_s, lt_u;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    always_comb begin
        case (d.br_kind)
            BR_EQ:              br_hit = eq;
            BR_NE:              br_hit = ~eq;
            BR_LT:              br_hit = lt_s;
            BR_GE:              br_hit = ~lt_s;
            BR_LTU:             br_hit = lt_u;
            BR_GEU:             br_hit = ~lt_u;
            BR_JIRL, BR_ALWAYS: br_hit = 1'b1;
            default:            br_hit = 1'b0;
        endcase
    end

    // jirl is register relative, all others pc relative
    assign br_target = ((d.br_kind == BR_JIRL) ? rj_value : slot_pc) + d.br_offs;
endmodule

// ==== logic/la_id_stage.sv ====
`timescale 1ns/10ps

module la_id_stage import la_id_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                in_valid,
    input  logic [XLEN-1:0]     in_pc,
    input  logic [XLEN-1:0]     in_inst,
    output logic                allowin,
    output logic                br_taken,
    output logic [XLEN-1:0]     br_target,
    output logic                br_stall,
    input  logic                ex_allowin,
    output logic                out_valid,
    output logic [ALU_OP_W-1:0] alu_op,
    output logic [XLEN-1:0]     alu_src1,
    output logic [XLEN-1:0]     alu_src2,
    output logic [REG_AW-1:0]   dest,
    output logic                gr_we,
    output logic [XLEN-1:0]     store_data,
    output logic                mem_load,
    output logic                mem_store,
    output logic [1:0]          mem_size,
    output logic                mem_unsigned,
    output logic                ine,
    output logic [XLEN-1:0]     out_pc,
    input  logic                ex_bypass,
    input  logic                ex_is_load,
    input  logic [REG_AW-1:0]   ex_dest,
    input  logic [XLEN-1:0]     ex_wdata,
    input  logic                mem_bypass,
    input  logic [REG_AW-1:0]   mem_dest,
    input  logic [XLEN-1:0]     mem_wdata,
    input  logic                wb_we,
    input  logic [REG_AW-1:0]   wb_dest,
    input  logic [XLEN-1:0]     wb_wdata
);
    logic            slot_valid;
    logic [XLEN-1:0] slot_pc;
    logic [XLEN-1:0] slot_inst;
    logic            ready_go;
    logic            br_hit;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;

    id_dec_if dec_bus ();

    id_latch u_id_latch (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_pc      (in_pc),
        .in_inst    (in_inst),
        .ready_go   (ready_go),
        .br_hit     (br_hit),
        .ex_allowin (ex_allowin),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .br_taken   (br_taken),
        .slot_valid (slot_valid),
        .slot_pc    (slot_pc),
        .slot_inst  (slot_inst)
    );

    inst_decoder u_inst_decoder (
        .slot_inst (slot_inst),
        .d         (dec_bus.dec)
    );

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .resetn     (resetn),
        .d          (dec_bus.user),
        .slot_valid (slot_valid),
        .slot_pc    (slot_pc),
        .ex_bypass  (ex_bypass),
        .ex_is_load (ex_is_load),
        .ex_dest    (ex_dest),
        .ex_wdata   (ex_wdata),
        .mem_bypass (mem_bypass),
        .mem_dest   (mem_dest),
        .mem_wdata  (mem_wdata),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_wdata   (wb_wdata),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .store_data (store_data),
        .ready_go   (ready_go),
        .br_stall   (br_stall)
    );

    branch_unit u_branch_unit (
        .d         (dec_bus.user),
        .slot_pc   (slot_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_hit    (br_hit),
        .br_target (br_target)
    );

    // decoded control straight out to execute
    assign alu_op       = dec_bus.alu_op;
    assign dest         = dec_bus.dest;
    assign gr_we        = dec_bus.gr_we;
    assign mem_load     = dec_bus.mem_load;
    assign mem_store    = dec_bus.mem_store;
    assign mem_size     = dec_bus.mem_size;
    assign mem_unsigned = dec_bus.mem_unsigned;
    assign ine          = dec_bus.ine;
    assign out_pc       = slot_pc;
endmodule

// ==== sim/tb_la_id_stage.sv ====
`timescale 1ns/10ps

module tb_la_id_stage import la_id_pkg::*; ();
    typedef struct packed {
        logic ex_bypass, ex_is_load, mem_bypass, wb_we;
        logic [REG_AW-1:0] ex_dest, mem_dest, wb_dest;
        logic [XLEN-1:0] ex_wdata, mem_wdata, wb_wdata;
    } fwd_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0] alu_op;
        logic [XLEN-1:0] src1, src2, store, target;
        logic [REG_AW-1:0] dest;
        logic [1:0] size;
        logic gr_we, ld, st, uns, ine, ready, hit, is_br;
    } exp_t;

    logic clk, resetn, in_valid, ex_allowin;
    logic [XLEN-1:0] in_pc, in_inst;
    logic allowin, br_taken, br_stall, out_valid, gr_we, mem_load, mem_store;
    logic mem_unsigned, ine;
    logic [XLEN-1:0] br_target, alu_src1, alu_src2, store_data, out_pc;
    logic [ALU_OP_W-1:0] alu_op;
    logic [REG_AW-1:0] dest;
    logic [1:0] mem_size;
    logic ex_bypass, ex_is_load, mem_bypass, wb_we;
    logic [REG_AW-1:0] ex_dest, mem_dest, wb_dest;
    logic [XLEN-1:0] ex_wdata, mem_wdata, wb_wdata;

    logic [XLEN-1:0] shadow [32]; // register file copy
    logic [XLEN-1:0] cur_pc, cur_inst;
    logic busy, exp_issue, exp_taken;
    int cycles = 0;

    logic [16:0] op17_list [14] = '{OP17_ADD_W, OP17_SUB_W, OP17_SLT, OP17_SLTU, OP17_NOR,
        OP17_AND, OP17_OR, OP17_XOR, OP17_SLL_W, OP17_SRL_W, OP17_SRA_W, OP17_SLLI_W,
        OP17_SRLI_W, OP17_SRAI_W};
    int alu17 [14] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLL, ALU_SRL, ALU_SRA};
    logic [9:0] op10_list [14] = '{OP10_SLTI, OP10_SLTUI, OP10_ADDI_W, OP10_ANDI, OP10_ORI,
        OP10_XORI, OP10_LD_B, OP10_LD_H, OP10_LD_W, OP10_LD_BU, OP10_LD_HU, OP10_ST_B,
        OP10_ST_H, OP10_ST_W};
    int alu10 [6] = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
    logic [5:0] op6_list [9] = '{OP6_JIRL, OP6_B, OP6_BL, OP6_BEQ, OP6_BNE, OP6_BLT,
        OP6_BGE, OP6_BLTU, OP6_BGEU};

    la_id_stage u_la_id_stage (.*);

    always #20 clk = ~clk;

    function automatic logic [XLEN-1:0] fwd_val(input logic [REG_AW-1:0] ra, input logic need,
                                                input logic [XLEN-1:0] regs [32], input fwd_t f);
        if (need && ra != 0 && f.ex_bypass && f.ex_dest == ra) return f.ex_wdata;
        if (need && ra != 0 && f.mem_bypass && f.mem_dest == ra) return f.mem_wdata;
        if (need && ra != 0 && f.wb_we && f.wb_dest == ra) return f.wb_wdata;
        return (ra == 0) ? '0 : regs[ra];
    endfunction

    function automatic exp_t ref_decode(input logic [XLEN-1:0] pc, w,
                                        input logic [XLEN-1:0] regs [32], input fwd_t f);
        exp_t e;
        logic [REG_AW-1:0] r2;
        logic n1, n2, pc1, imm2;
        logic [XLEN-1:0] imm, offs, v1, v2;
        logic [3:0] br;
        e = '0;
        e.ine = 1'b1;
        e.size = MEM_W;
        e.dest = w[4:0];
        {n1, n2, pc1, imm2} = 4'b0;
        imm = '0;
        br = BR_NONE;
        r2 = w[14:10];
        offs = {{14{w[25]}}, w[25:10], 2'b0};
        for (int i = 0; i < 14; i++) begin
            if (w[31:15] == op17_list[i]) begin
                e.alu_op[alu17[i]] = 1'b1;
                {n1, e.gr_we, e.ine} = 3'b110;
                n2 = i < 11;
                imm2 = i >= 11;
                imm = {27'b0, w[14:10]}; // shift amount
            end
        end
        for (int i = 0; i < 14; i++) begin
            if (w[31:22] == op10_list[i]) begin
                {n1, imm2, e.ine} = 3'b110;
                imm = (i < 3 || i > 5) ? {{20{w[21]}}, w[21:10]} : {20'b0, w[21:10]};
                e.alu_op[(i < 6) ? alu10[i] : ALU_ADD] = 1'b1;
                e.gr_we = i < 11;
                e.ld = i >= 6 && i < 11;
                e.st = i >= 11;
                e.uns = i == 9 || i == 10;
                if (i >= 6) e.size = (i == 6 || i == 9 || i == 11) ? MEM_B :
                                     (i == 7 || i == 10 || i == 12) ? MEM_H : MEM_W;
                if (e.st) begin
                    n2 = 1'b1;
                    r2 = w[4:0];
                end
            end
        end
        if (w[31:25] == OP7_LU12I_W || w[31:25] == OP7_PCADDU12I) begin
            {imm2, e.gr_we, e.ine} = 3'b110;
            imm = {w[24:5], 12'b0};
            pc1 = w[31:25] == OP7_PCADDU12I;
            e.alu_op[pc1 ? ALU_ADD : ALU_LUI] = 1'b1;
        end
        for (int i = 0; i < 9; i++) begin
            if (w[31:26] == op6_list[i]) begin
                e.ine = 1'b0;
                br = (i == 0) ? BR_JIRL : (i < 3) ? BR_ALWAYS : 4'(i - 2); // eq..geu in order
                if (i == 0 || i == 2) begin
                    {pc1, imm2, e.gr_we} = 3'b111;
                    imm = 32'd4; // link address
                    e.alu_op[ALU_ADD] = 1'b1;
                end
                if (i == 1 || i == 2) offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
                if (i == 2) e.dest = 5'd1;
                n1 = i == 0 || i >= 3;
                if (i >= 3) begin
                    n2 = 1'b1;
                    r2 = w[4:0];
                end
            end
        end
        v1 = fwd_val(w[9:5], n1, regs, f);
        v2 = fwd_val(r2, n2, regs, f);
        e.ready = !(f.ex_is_load && ((n1 && w[9:5] != 0 && f.ex_dest == w[9:5])
                                  || (n2 && r2 != 0 && f.ex_dest == r2)));
        e.src1 = pc1 ? pc : v1;
        e.src2 = imm2 ? imm : v2;
        e.store = v2;
        e.is_br = br != BR_NONE;
        e.target = ((br == BR_JIRL) ? v1 : pc) + offs;
        case (br)
            BR_EQ:  e.hit = v1 == v2;
            BR_NE:  e.hit = v1 != v2;
            BR_LT:  e.hit = $signed(v1) < $signed(v2);
            BR_GE:  e.hit = $signed(v1) >= $signed(v2);
            BR_LTU: e.hit = v1 < v2;
            BR_GEU: e.hit = v1 >= v2;
            default: e.hit = e.is_br;
        endcase
        return e;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name,
                                    got, exp));
    endtask

    task automatic check_alu_op(input logic [ALU_OP_W-1:0] got, exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: alu_op got %b expected %b", $time,
                                    got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name,
                                    got, exp));
    endtask

    // slot model and shadow registers follow the accept, issue and squash rules
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) stop_on_error("Timeout: the run did not finish in 4000 cycles");
        if (!resetn) begin
            busy <= 1'b0;
        end else if (exp_taken) begin
            busy <= 1'b0;
        end else if (!busy || exp_issue) begin
            busy <= in_valid;
            if (in_valid) begin
                cur_pc <= in_pc;
                cur_inst <= in_inst;
            end
        end
        if (wb_we) shadow[wb_dest] <= wb_wdata;
    end

    always @(negedge clk) begin
        exp_t e;
        fwd_t f;
        f = {ex_bypass, ex_is_load, mem_bypass, wb_we, ex_dest, mem_dest, wb_dest,
             ex_wdata, mem_wdata, wb_wdata};
        exp_issue = 1'b0;
        exp_taken = 1'b0;
        if (resetn && busy) begin
            e = ref_decode(cur_pc, cur_inst, shadow, f);
            exp_issue = e.ready & ex_allowin;
            exp_taken = exp_issue & e.hit;
            check_bit("out_valid", out_valid, e.ready);
            check_bit("allowin", allowin, exp_issue);
            check_bit("br_taken", br_taken, exp_taken);
            check_bit("br_stall", br_stall, !e.ready & e.is_br);
            if (exp_taken) check_word("br_target", br_target, e.target);
            if (e.ready) begin
                check_alu_op(alu_op, e.alu_op);
                check_word("alu_src1", alu_src1, e.src1);
                check_word("alu_src2", alu_src2, e.src2);
                check_word("store_data", store_data, e.store);
                check_word("out_pc", out_pc, cur_pc);
                check_word("dest", 32'(dest), 32'(e.dest));
                check_word("mem_size", 32'(mem_size), 32'(e.size));
                check_bit("gr_we", gr_we, e.gr_we);
                check_bit("mem_load", mem_load, e.ld);
                check_bit("mem_store", mem_store, e.st);
                check_bit("mem_unsigned", mem_unsigned, e.uns);
                check_bit("ine", ine, e.ine);
            end
        end else if (resetn) begin
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("allowin", allowin, 1'b1);
            check_bit("br_taken", br_taken, 1'b0);
            check_bit("br_stall", br_stall, 1'b0);
        end
    end

    function automatic logic [XLEN-1:0] gen_word();
        case ($urandom % 5)
            0: return {op17_list[$urandom % 14], 15'($urandom)};
            1: return {op10_list[$urandom % 14], 22'($urandom)};
            2: return {($urandom % 2) ? OP7_LU12I_W : OP7_PCADDU12I, 25'($urandom)};
            3: return {op6_list[$urandom % 9], 26'($urandom)};
            default: return $urandom; // mostly unknown encodings
        endcase
    endfunction

    task automatic offer(input logic [XLEN-1:0] pc, w);
        in_valid <= 1'b1;
        in_pc <= pc;
        in_inst <= w;
        do @(negedge clk); while (!allowin);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_issue();
        do @(negedge clk); while (!(out_valid && ex_allowin));
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'h1411));
        clk = 1'b0;
        resetn = 1'b0;
        {in_valid, ex_allowin, ex_bypass, ex_is_load, mem_bypass, wb_we} = 6'b010000;
        {in_pc, in_inst, ex_wdata, mem_wdata, wb_wdata} = '0;
        {ex_dest, mem_dest, wb_dest} = '0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        for (int r = 0; r < 32; r++) begin // r0 write must have no effect
            @(posedge clk);
            wb_we <= 1'b1;
            wb_dest <= 5'(r);
            wb_wdata <= $urandom | 32'h1;
        end
        // random stream, registers 0..7 only so that forwarding hits are common
        for (int n = 0; n < 1800; n++) begin
            @(posedge clk);
            in_valid <= ($urandom % 4) != 0;
            in_pc <= $urandom & 32'hffff_fffc;
            in_inst <= gen_word() & 32'hffff_9ce7;
            ex_allowin <= ($urandom % 5) != 0;
            ex_bypass <= ($urandom % 3) == 0;
            ex_is_load <= ($urandom % 8) == 0;
            ex_dest <= 5'($urandom % 8);
            ex_wdata <= $urandom;
            mem_bypass <= ($urandom % 3) == 0;
            mem_dest <= 5'($urandom % 8);
            mem_wdata <= $urandom;
            wb_we <= ($urandom % 3) == 0;
            wb_dest <= 5'($urandom % 8);
            wb_wdata <= $urandom;
        end
        @(posedge clk);
        {in_valid, ex_allowin, ex_bypass, ex_is_load, mem_bypass, wb_we} <= 6'b010000;
        @(posedge clk);
        // load-use on rj, then release
        ex_is_load <= 1'b1;
        ex_dest <= 5'd4;
        offer(32'h100, {OP17_ADD_W, 5'd5, 5'd4, 5'd3});
        repeat (4) @(posedge clk);
        ex_is_load <= 1'b0;
        wait_issue();
        // stalled taken beq with a wrong-path word offered behind it
        ex_is_load <= 1'b1;
        offer(32'h200, {OP6_BEQ, 16'h0010, 5'd4, 5'd4});
        in_valid <= 1'b1;
        in_inst <= {OP17_OR, 5'd1, 5'd2, 5'd3};
        repeat (3) @(posedge clk);
        ex_is_load <= 1'b0;
        wait_issue();
        in_valid <= 1'b0;
        // back-pressure with all forwarding sources on r1
        ex_allowin <= 1'b0;
        {ex_bypass, mem_bypass, wb_we} <= 3'b111;
        {ex_dest, mem_dest, wb_dest} <= {5'd1, 5'd1, 5'd1};
        offer(32'h300, {OP17_ADD_W, 5'd1, 5'd1, 5'd3});
        repeat (5) @(posedge clk);
        ex_allowin <= 1'b1;
        wait_issue();
        {ex_bypass, mem_bypass, wb_we} <= 3'b000;
        // bl with a negative 26-bit offset
        offer(32'h400, {OP6_BL, 16'h0040, 10'h3ff});
        wait_issue();
        repeat (3) @(posedge clk);
        $display("Everything OK");
        $finish;
    end
endmodule

// ==== files.f ====
logic/la_id_pkg.sv
logic/id_dec_if.sv
logic/id_latch.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_fetch.sv
logic/branch_unit.sv
logic/la_id_stage.sv
sim/tb_la_id_stage.sv
